// File: build.f
rtl/agnus_pkg.sv
rtl/dma_enable_if.sv
rtl/beam_slot_timer.sv
rtl/dma_control_reg.sv
rtl/bus_arbiter.sv
rtl/agnus_dma_core.sv
verif/dma_checker.sv
verif/tb_agnus_dma.sv

// File: rtl/agnus_dma_core.sv
`timescale 1ns/100ps

module agnus_dma_core
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  turbo,
	input  logic                  bls,	// blitter slowdown from cpu side
	// cpu register bus
	input  logic                  aen,
	input  logic                  rd,
	input  logic                  hwr,
	input  logic                  lwr,
	input  agnus_pkg::word_t      data_in,
	input  agnus_pkg::reg_addr_t  address_in,
	// blitter status for dmaconr
	input  logic                  blit_busy,
	input  logic                  blit_zero,
	// dma channel requests
	input  logic                  dsk_req,
	input  logic                  dsk_wr,
	input  agnus_pkg::chip_addr_t dsk_address,
	input  agnus_pkg::reg_addr_t  dsk_reg_address,
	input  logic [3:0]            aud_req,
	input  agnus_pkg::chip_addr_t aud_address,
	input  agnus_pkg::reg_addr_t  aud_reg_address,
	input  logic                  bpl_req,
	input  agnus_pkg::chip_addr_t bpl_address,
	input  agnus_pkg::reg_addr_t  bpl_reg_address,
	input  logic                  spr_req,
	input  agnus_pkg::chip_addr_t spr_address,
	input  agnus_pkg::reg_addr_t  spr_reg_address,
	input  logic                  cop_req,
	input  agnus_pkg::chip_addr_t cop_address,
	input  agnus_pkg::reg_addr_t  cop_reg_address,
	input  logic                  blt_req,
	input  logic                  blt_we,
	input  agnus_pkg::chip_addr_t blt_address,
	input  agnus_pkg::reg_addr_t  blt_reg_address,
	// outputs
	output agnus_pkg::word_t      data_out,	// dmaconr only
	output agnus_pkg::chip_addr_t address_out,
	output agnus_pkg::reg_addr_t  reg_address_out,
	output logic                  dbr,
	output logic                  dbwe,
	output logic                  ack_spr,
	output logic                  ack_cop,
	output logic                  ack_blt,
	output logic                  strhor_denise,
	output logic                  strhor_paula
);

	logic cck;	// colour clock phase
	logic refresh;	// refresh slot

	dma_enable_if dma_en ();

	// --------------------------------------------------
	beam_slot_timer beam_slot_timer_inst
	(
		.clk           (clk),
		.reset         (reset),
		.cck           (cck),
		.refresh       (refresh),
		.strhor_denise (strhor_denise),
		.strhor_paula  (strhor_paula)
	);

	// control register sees the arbitrated register address
	dma_control_reg dma_control_reg_inst
	(
		.clk         (clk),
		.reset       (reset),
		.reg_address (reg_address_out),
		.data_in     (data_in),
		.blit_busy   (blit_busy),
		.blit_zero   (blit_zero),
		.dmaconr     (data_out),
		.en          (dma_en.ctrl)
	);

	bus_arbiter bus_arbiter_inst
	(
		.clk             (clk),
		.reset           (reset),
		.cck             (cck),
		.refresh         (refresh),
		.turbo           (turbo),
		.bls             (bls),
		.en              (dma_en.arb),
		.dsk_req         (dsk_req),
		.dsk_wr          (dsk_wr),
		.dsk_address     (dsk_address),
		.dsk_reg_address (dsk_reg_address),
		.aud_req         (aud_req),
		.aud_address     (aud_address),
		.aud_reg_address (aud_reg_address),
		.bpl_req         (bpl_req),
		.bpl_address     (bpl_address),
		.bpl_reg_address (bpl_reg_address),
		.spr_req         (spr_req),
		.spr_address     (spr_address),
		.spr_reg_address (spr_reg_address),
		.cop_req         (cop_req),
		.cop_address     (cop_address),
		.cop_reg_address (cop_reg_address),
		.blt_req         (blt_req),
		.blt_we          (blt_we),
		.blt_address     (blt_address),
		.blt_reg_address (blt_reg_address),
		.aen             (aen),
		.rd              (rd),
		.hwr             (hwr),
		.lwr             (lwr),
		.address_in      (address_in),
		.address_out     (address_out),
		.reg_address     (reg_address_out),
		.dbr             (dbr),
		.dbwe            (dbwe),
		.ack_spr         (ack_spr),
		.ack_cop         (ack_cop),
		.ack_blt         (ack_blt)
	);

endmodule

// File: rtl/agnus_pkg.sv
package agnus_pkg;

	// --------------------------------------------------
	// widths and types
	localparam int WORD_W      = 16;
	localparam int CHIP_ADDR_W = 20;	// chip ram word address
	localparam int REG_ADDR_W  = 8;	// 256 register words
	localparam int HPOS_W      = 9;
	localparam int DMACON_W    = 13;	// stored dmacon bits 12..0
	localparam int BLS_CNT_W   = 2;

	typedef logic [WORD_W-1:0]      word_t;
	typedef logic [CHIP_ADDR_W-1:0] chip_addr_t;
	typedef logic [REG_ADDR_W-1:0]  reg_addr_t;
	typedef logic [HPOS_W-1:0]      hpos_t;
	typedef logic [BLS_CNT_W-1:0]   bls_cnt_t;

	// register word indices
	localparam reg_addr_t REG_IDLE    = 8'hff;	// nothing addressed
	localparam reg_addr_t REG_DMACON  = 8'h4b;	// byte address 0x096
	localparam reg_addr_t REG_DMACONR = 8'h01;	// byte address 0x002

	// --------------------------------------------------
	// horizontal slot positions
	localparam hpos_t HPOS_LAST         = 9'd453;	// 454 slots per line
	localparam hpos_t REFRESH_FIRST     = 9'd1;
	localparam hpos_t REFRESH_LAST      = 9'd7;
	localparam hpos_t STRHOR_DENISE_POS = 9'd11;
	localparam hpos_t STRHOR_PAULA_POS  = 9'd13;

	// cpu missed three slots in a row
	localparam bls_cnt_t BLS_CNT_MAX = 2'd3;

	// dmacon bit positions
	localparam int DMACON_SETCLR = 15;
	localparam int DMACON_BBUSY  = 14;	// read only
	localparam int DMACON_BZERO  = 13;	// read only
	localparam int DMACON_BLTPRI = 10;
	localparam int DMACON_DMAEN  = 9;	// master enable
	localparam int DMACON_BPLEN  = 8;
	localparam int DMACON_COPEN  = 7;
	localparam int DMACON_BLTEN  = 6;
	localparam int DMACON_SPREN  = 5;
	localparam int DMACON_DSKEN  = 4;
	localparam int DMACON_AUD_HI = 3;
	localparam int DMACON_AUD_LO = 0;

	// who owns the current slot
	typedef enum logic [2:0] {
		OWNER_NONE,
		OWNER_DSK,
		OWNER_REF,
		OWNER_AUD,
		OWNER_BPL,
		OWNER_SPR,
		OWNER_COP,
		OWNER_BLT
	} bus_owner_e;

endpackage

// File: rtl/beam_slot_timer.sv
`timescale 1ns/100ps

module beam_slot_timer
(
	input  logic clk,
	input  logic reset,
	output logic cck,	// colour clock phase, odd slots
	output logic refresh,	// refresh slot
	output logic strhor_denise,	// horizontal strobe to denise
	output logic strhor_paula	// horizontal strobe to paula
);
	import agnus_pkg::*;

	hpos_t hpos;	// current slot in the line

	// --------------------------------------------------
	// horizontal slot counter
	always_ff @(posedge clk)
	begin
		if (reset)
			hpos <= '0;
		else if (hpos == HPOS_LAST)
			hpos <= '0;	// wrap at end of line
		else
			hpos <= hpos + hpos_t'(1);
	end

	// --------------------------------------------------
	// slot decodes

	// odd slots belong to the chipset
	assign cck = hpos[0];

	// refresh uses the odd slots at the start of each line
	assign refresh = hpos[0] && (hpos >= REFRESH_FIRST) && (hpos <= REFRESH_LAST);

	// denise strobe runs one cck ahead of paula
	// to cover the pipeline delay on the display side
	assign strhor_denise = (hpos == STRHOR_DENISE_POS);
	assign strhor_paula  = (hpos == STRHOR_PAULA_POS);

endmodule

// File: rtl/bus_arbiter.sv
`timescale 1ns/100ps

module bus_arbiter
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  cck,	// odd slot
	input  logic                  refresh,	// refresh slot
	input  logic                  turbo,	// blitter may take even slots too
	input  logic                  bls,	// cpu is waiting for the bus
	dma_enable_if.arb             en,
	// disk
	input  logic                  dsk_req,
	input  logic                  dsk_wr,
	input  agnus_pkg::chip_addr_t dsk_address,
	input  agnus_pkg::reg_addr_t  dsk_reg_address,
	// audio
	input  logic [3:0]            aud_req,
	input  agnus_pkg::chip_addr_t aud_address,
	input  agnus_pkg::reg_addr_t  aud_reg_address,
	// bitplane
	input  logic                  bpl_req,
	input  agnus_pkg::chip_addr_t bpl_address,
	input  agnus_pkg::reg_addr_t  bpl_reg_address,
	// sprite
	input  logic                  spr_req,
	input  agnus_pkg::chip_addr_t spr_address,
	input  agnus_pkg::reg_addr_t  spr_reg_address,
	// copper
	input  logic                  cop_req,
	input  agnus_pkg::chip_addr_t cop_address,
	input  agnus_pkg::reg_addr_t  cop_reg_address,
	// blitter
	input  logic                  blt_req,
	input  logic                  blt_we,
	input  agnus_pkg::chip_addr_t blt_address,
	input  agnus_pkg::reg_addr_t  blt_reg_address,
	// cpu side register access
	input  logic                  aen,
	input  logic                  rd,
	input  logic                  hwr,
	input  logic                  lwr,
	input  agnus_pkg::reg_addr_t  address_in,
	// bus outputs
	output agnus_pkg::chip_addr_t address_out,
	output agnus_pkg::reg_addr_t  reg_address,
	output logic                  dbr,	// agnus owns the data bus
	output logic                  dbwe,	// memory write cycle
	output logic                  ack_spr,
	output logic                  ack_cop,
	output logic                  ack_blt
);
	import agnus_pkg::*;

	bus_owner_e owner;	// winner of this slot
	bls_cnt_t   bls_cnt;	// cycles the cpu has missed the bus
	reg_addr_t  cpu_reg_address;

	// cpu address only counts during an actual access
	assign cpu_reg_address = (aen && (rd || hwr || lwr)) ? address_in : REG_IDLE;

	// --------------------------------------------------
	// fixed priority, first match wins
	always_comb
	begin
		if (dsk_req && en.dsk_en)
			owner = OWNER_DSK;
		else if (refresh)
			owner = OWNER_REF;
		else if (|(aud_req & en.aud_en))
			owner = OWNER_AUD;
		else if (bpl_req && en.bpl_en)
			owner = OWNER_BPL;
		else if (spr_req && en.spr_en)
			owner = OWNER_SPR;
		else if (cop_req && en.cop_en)
			owner = OWNER_COP;
		else if (blt_req && en.blt_en && (bls_cnt != BLS_CNT_MAX))
			owner = OWNER_BLT;	// locked out once the cpu starved
		else
			owner = OWNER_NONE;
	end

	// bus multiplexer
	always_comb
	begin
		dbr         = 1'b1;
		dbwe        = 1'b0;
		ack_spr     = 1'b0;
		ack_cop     = 1'b0;
		ack_blt     = 1'b0;
		address_out = '0;
		reg_address = REG_IDLE;
		case (owner)
			OWNER_DSK:
			begin
				address_out = dsk_address;
				reg_address = dsk_reg_address;
				dbwe        = dsk_wr;	// disk can write memory
			end
			OWNER_REF:
			begin
				address_out = '0;	// refresh cycle, no register
				reg_address = REG_IDLE;
			end
			OWNER_AUD:
			begin
				address_out = aud_address;
				reg_address = aud_reg_address;
			end
			OWNER_BPL:
			begin
				address_out = bpl_address;
				reg_address = bpl_reg_address;
			end
			OWNER_SPR:
			begin
				address_out = spr_address;
				reg_address = spr_reg_address;
				ack_spr     = 1'b1;
			end
			OWNER_COP:
			begin
				address_out = cop_address;
				reg_address = cop_reg_address;
				ack_cop     = 1'b1;
			end
			OWNER_BLT:
			begin
				address_out = blt_address;
				reg_address = blt_reg_address;
				dbwe        = blt_we;
				ack_blt     = 1'b1;
			end
			OWNER_NONE:
			begin
				dbr         = 1'b0;	// bus left to the cpu
				reg_address = cpu_reg_address;
			end
		endcase
	end

	// --------------------------------------------------
	// blitter slowdown counter
	always_ff @(posedge clk)
	begin
		if (reset)
			bls_cnt <= '0;
		else if (!cck || turbo)
		begin
			if (!bls || en.blt_pri)
				bls_cnt <= '0;	// cpu got through or nasty mode
			else if (bls_cnt != BLS_CNT_MAX)
				bls_cnt <= bls_cnt + bls_cnt_t'(1);	// saturates at max
		end
	end

endmodule

// File: rtl/dma_control_reg.sv
`timescale 1ns/100ps

module dma_control_reg
(
	input  logic                 clk,
	input  logic                 reset,
	input  agnus_pkg::reg_addr_t reg_address,	// current register address bus
	input  agnus_pkg::word_t     data_in,
	input  logic                 blit_busy,	// blitter status
	input  logic                 blit_zero,
	output agnus_pkg::word_t     dmaconr,	// read word, zero when not addressed
	dma_enable_if.ctrl           en
);
	import agnus_pkg::*;

	logic [DMACON_W-1:0] dmacon;	// stored control bits
	logic                dmacon_wr;	// write strobe
	logic                master;	// dmaen bit

	assign dmacon_wr = (reg_address == REG_DMACON);

	// --------------------------------------------------
	// dmacon write with set/clear rule
	always_ff @(posedge clk)
	begin
		if (reset)
			dmacon <= '0;
		else if (dmacon_wr)
		begin
			if (data_in[DMACON_SETCLR])
				dmacon <= dmacon | data_in[DMACON_W-1:0];	// set the given bits
			else
				dmacon <= dmacon & ~data_in[DMACON_W-1:0];	// clear the given bits
		end
	end

	// dmaconr read word
	always_comb
	begin
		dmaconr = '0;
		if (reg_address == REG_DMACONR)
		begin
			dmaconr[DMACON_W-1:0] = dmacon;
			dmaconr[DMACON_BZERO] = blit_zero;
			dmaconr[DMACON_BBUSY] = blit_busy;
			// bit 15 always reads back as zero
		end
	end

	// --------------------------------------------------
	// channel enables
	assign master = dmacon[DMACON_DMAEN];

	assign en.dsk_en  = dmacon[DMACON_DSKEN] & master;
	assign en.aud_en  = dmacon[DMACON_AUD_HI:DMACON_AUD_LO] & {4{master}};
	assign en.bpl_en  = dmacon[DMACON_BPLEN] & master;
	assign en.cop_en  = dmacon[DMACON_COPEN] & master;
	assign en.blt_en  = dmacon[DMACON_BLTEN] & master;
	assign en.spr_en  = dmacon[DMACON_SPREN] & master;
	assign en.blt_pri = dmacon[DMACON_BLTPRI];	// master does not apply here

endmodule

// File: rtl/dma_enable_if.sv
`timescale 1ns/100ps

interface dma_enable_if;

	// all channel enables already gated with the master bit
	logic       dsk_en;
	logic [3:0] aud_en;	// one per audio channel
	logic       bpl_en;
	logic       cop_en;
	logic       blt_en;
	logic       spr_en;
	logic       blt_pri;	// blitter nasty, not gated

	modport ctrl (output dsk_en, aud_en, bpl_en, cop_en, blt_en, spr_en, blt_pri);

	modport arb (input dsk_en, aud_en, bpl_en, cop_en, blt_en, spr_en, blt_pri);

endinterface

// File: run_sim.sh
#!/bin/sh
# compile and run the agnus dma core testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module tb_agnus_dma -o sim_agnus
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

./obj_dir/sim_agnus > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
	exit 1
fi

if ! grep -q "RESULT: PASS" sim.log; then
	echo "no pass line found in sim.log"
	exit 1
fi

exit 0

// File: verif/agnus_dma_trace.txt
# test reset turbo bls aen rd hwr lwr data_in address_in busy zero dsk dsk_wr aud bpl spr cop blt blt_we
#   then expected: data_out address_out reg_address_out dbr dbwe ack_spr ack_cop ack_blt den paula
1 0 0 0 1 1 0 0 0000 01 0 0 0 0 0 0 0 0 0 0  0000 00000 01 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0000 00 0 0 0 0 0 0 0 0 0 0  0000 00000 ff 1 0 0 0 0 0 0
1 0 0 0 1 1 0 0 0000 01 0 0 0 0 0 0 0 0 0 0  0000 00000 01 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0000 00 0 0 0 0 0 0 0 0 0 0  0000 00000 ff 1 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0000 00 0 0 0 0 0 0 0 0 0 0  0000 00000 ff 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0000 00 0 0 0 0 0 0 0 0 0 0  0000 00000 ff 1 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0000 00 0 0 0 0 0 0 0 0 0 0  0000 00000 ff 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0000 00 0 0 0 0 0 0 0 0 0 0  0000 00000 ff 1 0 0 0 0 0 0
6 0 0 0 1 0 0 0 0000 33 0 0 0 0 0 0 0 0 0 0  0000 00000 ff 0 0 0 0 0 0 0
6 0 0 0 1 0 0 1 0000 33 0 0 0 0 0 0 0 0 0 0  0000 00000 33 0 0 0 0 0 0 0
6 0 0 0 0 1 0 0 0000 33 0 0 0 0 0 0 0 0 0 0  0000 00000 ff 0 0 0 0 0 0 0
6 0 0 0 1 0 1 0 0000 7e 0 0 0 0 0 0 0 0 0 0  0000 00000 7e 0 0 0 0 0 1 0
6 0 0 0 1 1 0 0 0000 5a 0 0 0 0 0 0 0 0 0 0  0000 00000 5a 0 0 0 0 0 0 0
6 0 0 0 0 0 0 0 0000 00 0 0 0 0 0 0 0 0 0 0  0000 00000 ff 0 0 0 0 0 0 1
2 1 0 0 0 0 0 0 0000 00 0 0 0 0 0 0 0 0 0 0  0000 00000 ff 0 0 0 0 0 0 0
2 0 0 0 1 0 1 0 83ff 4b 0 0 0 0 0 0 0 0 0 0  0000 00000 4b 0 0 0 0 0 0 0
4 0 0 0 0 0 0 0 0000 00 0 0 0 0 f 1 1 1 1 0  0000 00000 ff 1 0 0 0 0 0 0
4 0 0 0 0 0 0 0 0000 00 0 0 0 0 f 1 1 1 1 0  0000 22220 55 1 0 0 0 0 0 0
4 0 0 0 0 0 0 0 0000 00 0 0 0 0 f 1 1 1 1 0  0000 00000 ff 1 0 0 0 0 0 0
4 0 0 0 0 0 0 0 0000 00 0 0 0 0 0 0 0 0 0 0  0000 00000 ff 0 0 0 0 0 0 0
4 0 0 0 0 0 0 0 0000 00 0 0 1 1 f 1 1 1 1 0  0000 11110 10 1 1 0 0 0 0 0
4 0 0 0 0 0 0 0 0000 00 0 0 0 0 0 0 0 0 0 0  0000 00000 ff 0 0 0 0 0 0 0
4 0 0 0 0 0 0 0 0000 00 0 0 0 0 f 1 1 1 1 0  0000 00000 ff 1 0 0 0 0 0 0
2 0 0 0 1 1 0 0 0000 01 1 0 0 0 0 0 0 0 0 0  43ff 00000 01 0 0 0 0 0 0 0
2 0 0 0 1 0 1 0 000f 4b 0 0 0 0 0 0 0 0 0 0  0000 00000 4b 0 0 0 0 0 0 0
2 0 0 0 1 1 0 0 0000 01 0 1 0 0 0 0 0 0 0 0  23f0 00000 01 0 0 0 0 0 0 0
2 0 0 0 1 0 1 0 800f 4b 0 0 0 0 0 0 0 0 0 0  0000 00000 4b 0 0 0 0 0 1 0
2 0 0 0 1 1 0 0 0000 01 1 1 0 0 0 0 0 0 0 0  63ff 00000 01 0 0 0 0 0 0 0
3 0 0 0 0 0 0 0 0000 00 0 0 1 1 f 1 1 1 1 1  0000 11110 10 1 1 0 0 0 0 1
3 0 0 0 0 0 0 0 0000 00 0 0 0 0 2 1 1 1 1 1  0000 22220 55 1 0 0 0 0 0 0
3 0 0 0 0 0 0 0 0000 00 0 0 0 0 0 1 1 1 1 1  0000 33330 88 1 0 0 0 0 0 0
3 0 0 0 0 0 0 0 0000 00 0 0 0 0 0 0 1 1 1 1  0000 44440 a0 1 0 1 0 0 0 0
3 0 0 0 0 0 0 0 0000 00 0 0 0 0 0 0 0 1 1 1  0000 55550 40 1 0 0 1 0 0 0
3 0 0 0 0 0 0 0 0000 00 0 0 0 0 0 0 0 0 1 1  0000 66660 20 1 1 0 0 1 0 0
3 0 0 0 0 0 0 0 0000 00 0 0 0 0 0 0 0 0 0 0  0000 00000 ff 0 0 0 0 0 0 0
5 0 0 1 0 0 0 0 0000 00 0 0 0 0 0 0 0 0 1 0  0000 66660 20 1 0 0 0 1 0 0
5 0 0 1 0 0 0 0 0000 00 0 0 0 0 0 0 0 0 1 0  0000 66660 20 1 0 0 0 1 0 0
5 0 0 1 0 0 0 0 0000 00 0 0 0 0 0 0 0 0 1 0  0000 66660 20 1 0 0 0 1 0 0
5 0 0 1 0 0 0 0 0000 00 0 0 0 0 0 0 0 0 1 0  0000 66660 20 1 0 0 0 1 0 0
5 0 0 1 0 0 0 0 0000 00 0 0 0 0 0 0 0 0 1 0  0000 66660 20 1 0 0 0 1 0 0
5 0 0 1 0 0 0 0 0000 00 0 0 0 0 0 0 0 0 1 0  0000 00000 ff 0 0 0 0 0 0 0
5 0 0 0 0 0 0 0 0000 00 0 0 0 0 0 0 0 0 1 0  0000 00000 ff 0 0 0 0 0 0 0
5 0 0 0 0 0 0 0 0000 00 0 0 0 0 0 0 0 0 1 0  0000 66660 20 1 0 0 0 1 0 0
5 0 0 1 0 0 0 0 0000 00 0 0 0 0 0 0 0 0 1 0  0000 66660 20 1 0 0 0 1 0 0
5 0 0 1 0 0 0 0 0000 00 0 0 0 0 0 0 0 0 1 0  0000 66660 20 1 0 0 0 1 0 0
5 0 0 1 0 0 0 0 0000 00 0 0 0 0 0 0 0 0 1 0  0000 66660 20 1 0 0 0 1 0 0
5 0 0 1 0 0 0 0 0000 00 0 0 0 0 0 0 0 0 1 0  0000 66660 20 1 0 0 0 1 0 0
5 0 0 1 0 0 0 0 0000 00 0 0 0 0 0 0 0 0 1 0  0000 66660 20 1 0 0 0 1 0 0
5 0 0 1 0 0 0 0 0000 00 0 0 0 0 0 0 0 0 1 0  0000 00000 ff 0 0 0 0 0 0 0
5 0 0 1 1 0 1 0 8400 4b 0 0 0 0 0 0 0 0 1 0  0000 00000 4b 0 0 0 0 0 0 0
5 0 1 1 0 0 0 0 0000 00 0 0 0 0 0 0 0 0 1 0  0000 00000 ff 0 0 0 0 0 0 0
5 0 0 1 0 0 0 0 0000 00 0 0 0 0 0 0 0 0 1 0  0000 66660 20 1 0 0 0 1 0 0
5 0 0 1 0 0 0 0 0000 00 0 0 0 0 0 0 0 0 1 0  0000 66660 20 1 0 0 0 1 0 0

// File: verif/dma_checker.sv
`timescale 1ns/100ps

module dma_checker
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  check_en,	// low on reset lines of the trace
	input  logic                  done,	// trace finished
	input  int                    test_num,
	// expected values from the trace
	input  agnus_pkg::word_t      exp_data,
	input  agnus_pkg::chip_addr_t exp_addr,
	input  agnus_pkg::reg_addr_t  exp_reg,
	input  logic [6:0]            exp_bits,	// dbr dbwe ack_spr ack_cop ack_blt den paula
	// dut outputs
	input  agnus_pkg::word_t      data_out,
	input  agnus_pkg::chip_addr_t address_out,
	input  agnus_pkg::reg_addr_t  reg_address_out,
	input  logic                  dbr,
	input  logic                  dbwe,
	input  logic                  ack_spr,
	input  logic                  ack_cop,
	input  logic                  ack_blt,
	input  logic                  strhor_denise,
	input  logic                  strhor_paula,
	output int                    err_total,
	output int                    check_total
);

	int cur_test;	// -1 until the first checked line
	int test_checks;
	int test_errs;
	int wait_cnt;
	bit reset_seen;

	task automatic compare_field(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		check_total++;
		test_checks++;
		if (exp !== act)
		begin
			$display("ERR %0t %s expected %0h got %0h", $time, name, exp, act);
			err_total++;
			test_errs++;
		end
	endtask

	task automatic report_test();
		$display("test %0d done: %0d checks, %0d errors", cur_test, test_checks, test_errs);
	endtask

	// --------------------------------------------------
	// wait for the first reset release
	initial
	begin
		err_total   = 0;
		check_total = 0;
		cur_test    = -1;
		test_checks = 0;
		test_errs   = 0;
		reset_seen  = 0;
		wait_cnt    = 0;
		while (reset !== 1'b0 && wait_cnt < 100)
		begin
			@(negedge clk);
			#2;	// reset is driven on the falling edge
			wait_cnt++;
		end
		if (reset !== 1'b0)
		begin
			$display("reset was not released within 100 cycles");
			err_total++;
		end
		else
			reset_seen = 1;
	end

	// --------------------------------------------------
	// sample late in the cycle, inputs changed on the falling edge
	always @(negedge clk)
	begin
		#4;
		if (check_en && reset_seen)
		begin
			if (test_num != cur_test)
			begin
				if (cur_test >= 0)
					report_test();	// previous test is complete
				cur_test    = test_num;
				test_checks = 0;
				test_errs   = 0;
			end
			compare_field("data_out", 32'(exp_data), 32'(data_out));
			compare_field("address_out", 32'(exp_addr), 32'(address_out));
			compare_field("reg_address_out", 32'(exp_reg), 32'(reg_address_out));
			compare_field("dbr", 32'(exp_bits[6]), 32'(dbr));
			compare_field("dbwe", 32'(exp_bits[5]), 32'(dbwe));
			compare_field("ack_spr", 32'(exp_bits[4]), 32'(ack_spr));
			compare_field("ack_cop", 32'(exp_bits[3]), 32'(ack_cop));
			compare_field("ack_blt", 32'(exp_bits[2]), 32'(ack_blt));
			compare_field("strhor_denise", 32'(exp_bits[1]), 32'(strhor_denise));
			compare_field("strhor_paula", 32'(exp_bits[0]), 32'(strhor_paula));
		end
	end

	// closing counts
	always @(posedge done)
	begin
		if (cur_test >= 0)
			report_test();
		$display("total: %0d checks, %0d errors", check_total, err_total);
	end

endmodule

// File: verif/tb_agnus_dma.sv
`timescale 1ns/100ps

module tb_agnus_dma;
	import agnus_pkg::*;

	localparam int MAX_LINES = 1000;	// trace read limit

	// fixed channel addresses, register targets avoid dmacon and dmaconr
	localparam chip_addr_t DSK_ADDR = 20'h11110;
	localparam chip_addr_t AUD_ADDR = 20'h22220;
	localparam chip_addr_t BPL_ADDR = 20'h33330;
	localparam chip_addr_t SPR_ADDR = 20'h44440;
	localparam chip_addr_t COP_ADDR = 20'h55550;
	localparam chip_addr_t BLT_ADDR = 20'h66660;

	logic clk, reset, turbo, bls, aen, rd, hwr, lwr, blit_busy, blit_zero;
	word_t data_in;
	reg_addr_t address_in;
	logic dsk_req, dsk_wr, bpl_req, spr_req, cop_req, blt_req, blt_we;
	logic [3:0] aud_req;
	chip_addr_t dsk_address, aud_address, bpl_address, spr_address, cop_address, blt_address;
	reg_addr_t dsk_reg_address, aud_reg_address, bpl_reg_address;
	reg_addr_t spr_reg_address, cop_reg_address, blt_reg_address;
	word_t data_out;
	chip_addr_t address_out;
	reg_addr_t reg_address_out;
	logic dbr, dbwe, ack_spr, ack_cop, ack_blt, strhor_denise, strhor_paula;

	// trace side
	word_t exp_data;
	chip_addr_t exp_addr;
	reg_addr_t exp_reg;
	logic [6:0] exp_bits;
	logic check_en, done;
	int test_num, err_total, check_total;
	int seed, fd;
	int f [30];	// one parsed trace line
	string line_str;
	bit timed_out, bad_line, open_fail;

	// --------------------------------------------------
	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	agnus_dma_core agnus_dma_core_inst (.*);

	dma_checker dma_checker_inst (.*);

	// idle channels get random addresses, nothing may see them
	task automatic apply_line();
		test_num   = f[0];
		reset      = f[1][0];
		check_en   = !f[1][0];
		turbo      = f[2][0];
		bls        = f[3][0];
		aen        = f[4][0];
		rd         = f[5][0];
		hwr        = f[6][0];
		lwr        = f[7][0];
		data_in    = f[8][15:0];
		address_in = aen ? f[9][7:0] : reg_addr_t'($random(seed));
		blit_busy  = f[10][0];
		blit_zero  = f[11][0];
		dsk_req    = f[12][0];
		dsk_wr     = f[13][0];
		aud_req    = f[14][3:0];
		bpl_req    = f[15][0];
		spr_req    = f[16][0];
		cop_req    = f[17][0];
		blt_req    = f[18][0];
		blt_we     = f[19][0];
		dsk_address = dsk_req ? DSK_ADDR : chip_addr_t'($random(seed));
		aud_address = (aud_req != 4'h0) ? AUD_ADDR : chip_addr_t'($random(seed));
		bpl_address = bpl_req ? BPL_ADDR : chip_addr_t'($random(seed));
		spr_address = spr_req ? SPR_ADDR : chip_addr_t'($random(seed));
		cop_address = cop_req ? COP_ADDR : chip_addr_t'($random(seed));
		blt_address = blt_req ? BLT_ADDR : chip_addr_t'($random(seed));
		exp_data = f[20][15:0];
		exp_addr = f[21][19:0];
		exp_reg  = f[22][7:0];
		exp_bits = {f[23][0], f[24][0], f[25][0], f[26][0], f[27][0], f[28][0], f[29][0]};
	endtask

	// one trace line per clock, lines starting with # are skipped
	task automatic run_trace();
		int n;
		int line_cnt;
		line_cnt = 0;
		while (!$feof(fd) && !timed_out && !bad_line)
		begin
			line_str = "";
			n = $fgets(line_str, fd);
			if (n > 0 && line_str.len() > 1 && line_str.getc(0) != "#")
			begin
				n = $sscanf(line_str,
					"%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
					f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19],
					f[20], f[21], f[22], f[23], f[24], f[25], f[26], f[27], f[28], f[29]);
				if (n != 30)
				begin
					$display("malformed trace line: %s", line_str);
					bad_line = 1;
				end
				else
				begin
					apply_line();
					@(negedge clk);
				end
			end
			line_cnt++;
			if (line_cnt > MAX_LINES)
			begin
				$display("trace reading ran past %0d lines", MAX_LINES);
				timed_out = 1;
			end
		end
		$fclose(fd);
	endtask

	// --------------------------------------------------
	initial
	begin
		seed = 32'hce661b80;
		reset = 1'b1;
		{turbo, bls, aen, rd, hwr, lwr, blit_busy, blit_zero} = '0;
		{dsk_req, dsk_wr, bpl_req, spr_req, cop_req, blt_req, blt_we} = '0;
		aud_req = '0;
		data_in = '0;
		address_in = '0;
		{dsk_address, aud_address, bpl_address} = '0;
		{spr_address, cop_address, blt_address} = '0;
		dsk_reg_address = 8'h10;
		aud_reg_address = 8'h55;
		bpl_reg_address = 8'h88;
		spr_reg_address = 8'ha0;
		cop_reg_address = 8'h40;
		blt_reg_address = 8'h20;
		{exp_data, exp_addr, exp_reg, exp_bits} = '0;
		check_en = 1'b0;
		done = 1'b0;
		test_num = 0;
		fd = $fopen("verif/agnus_dma_trace.txt", "r");
		repeat (8) @(posedge clk);
		@(negedge clk);	// first line releases reset
		if (fd == 0)
		begin
			$display("trace file verif/agnus_dma_trace.txt could not be opened");
			open_fail = 1;
		end
		else
			run_trace();
		check_en = 1'b0;
		done = 1'b1;
		#1;
		if (open_fail || timed_out || bad_line || err_total != 0 || check_total == 0)
			$display("RESULT: FAIL");
		else
			$display("RESULT: PASS");
		$finish;
	end

endmodule
